//--- include/ahb_params.svh
// Bus widths, memory depth and memory wait-state count for the AHB subsystem
`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

// Physical address width in bits
`define PA_BITS 32

// Data bus width in bits
// Byte strobes are XLEN/8 wide
`define XLEN 32

// Memory depth in words
// Must stay a power of two so the word index wraps
`define MEM_WORDS 1024

// Low HREADY cycles at the start of each data phase
// 0, 1 and 2 are the supported values
`define MEM_WAIT_STATES 0

`endif

//--- verilog/ahbPkg.sv
// AHB-Lite transfer type and burst type enums, address-phase struct
`include "ahb_params.svh"

package ahbPkg;

  // HTRANS encodings as defined by AHB-Lite
  typedef enum logic [1:0] {
    HtIdle   = 2'b00,
    HtBusy   = 2'b01,
    HtNonSeq = 2'b10,
    HtSeq    = 2'b11
  } hTransT;

  // HBURST encodings as defined by AHB-Lite
  // Only incrementing bursts are carried
  typedef enum logic [2:0] {
    HbSingle = 3'b000,
    HbIncr   = 3'b001,
    HbIncr4  = 3'b011,
    HbIncr8  = 3'b101,
    HbIncr16 = 3'b111
  } hBurstT;

  // Everything a manager drives in the address phase
  typedef struct packed {
    logic [`PA_BITS-1:0] addr;
    logic                write;
    logic [2:0]          size;
    hBurstT              burst;
    hTransT              trans;
  } ahbAddrPhaseT;

endpackage

//--- verilog/arbPkg.sv
// Arbitration state enum and fetch request struct
`include "ahb_params.svh"

package arbPkg;

  import ahbPkg::*;

  // ArbHold means the load/store port owns the bus with a fetch parked
  typedef enum logic {
    ArbIdle,
    ArbHold
  } arbStateT;

  // Fetch is always a word read, so no size or write field
  typedef struct packed {
    logic [`PA_BITS-1:0] addr;
    hBurstT              burst;
    hTransT              trans;
  } fetchReqT;

endpackage

//--- verilog/fetchInputStage.sv
// Fetch input stage that parks a losing fetch address phase and replays it
module fetchInputStage import arbPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  fetchReqT req,
  input  logic     busReady,
  input  logic     save,
  input  logic     restore,
  output fetchReqT reqOut,
  output logic     pending,
  output logic     stageReady
);

  fetchReqT savedReq;
  logic     replayAccepted;

  // Capture the fetch address phase that the load/store port beat
  always_ff @(posedge clk) begin
    if (save) begin
      savedReq <= req;
    end
  end

  // Replayed beat goes out while restore is high
  // Accepted on the first edge with the bus ready
  assign replayAccepted = restore & busReady & pending;

  // Pending flag
  // Set by the arbiter on a lost start, cleared once the replay is on the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (save) begin
      pending <= 1'b1;
    end else if (replayAccepted) begin
      pending <= 1'b0;
    end
  end

  // Saved request overrides the live one during replay
  assign reqOut = restore ? savedReq : req;

  // Fetch manager sees a stall while its beat is parked
  // so it keeps its next address phase steady
  assign stageReady = busReady & ~pending;

endmodule

//--- verilog/ahbMultiManager.sv
// Two-manager AHB-Lite arbiter with fetch parking, burst hold and address mux
`include "ahb_params.svh"

module ahbMultiManager import ahbPkg::*, arbPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  fetchReqT           fetchReq,
  input  ahbAddrPhaseT       lsuReq,
  input  logic [`XLEN-1:0]   lsuWdata,
  input  logic [`XLEN/8-1:0] lsuWstrb,
  input  logic               busReady,
  output logic               fetchReady,
  output logic               lsuReady,
  output ahbAddrPhaseT       busAddr,
  output logic [`XLEN-1:0]   busWdata,
  output logic [`XLEN/8-1:0] busWstrb
);

  arbStateT   state;
  arbStateT   nextState;
  fetchReqT   fetchOut;
  logic       fetchPending;
  logic       lsuActive;
  logic       fetchActive;
  logic       save;
  logic       restore;
  logic       fetchSel;
  logic       lsuBeat;
  logic [3:0] beatCount;
  logic [3:0] beatCountD;
  logic [3:0] threshold;
  hBurstT     burstD;
  logic       finalBeat;

  // Parking slot for the fetch port
  fetchInputStage i_fetchInputStage (
    .clk        (clk),
    .reset      (reset),
    .req        (fetchReq),
    .busReady   (busReady),
    .save       (save),
    .restore    (restore),
    .reqOut     (fetchOut),
    .pending    (fetchPending),
    .stageReady (fetchReady)
  );

  // NonSeq or Seq counts as a live request
  assign lsuActive   = (lsuReq.trans == HtNonSeq) | (lsuReq.trans == HtSeq);
  assign fetchActive = (fetchReq.trans == HtNonSeq) | (fetchReq.trans == HtSeq);

  ////////////////////////////////////////
  // Arbitration FSM
  ////////////////////////////////////////

  // Load/store port wins when both ports are accepted on one edge
  assign save = (state == ArbIdle) & lsuActive & fetchActive & busReady & ~fetchPending;

  // Replay once the held burst is past its last beat and load/store goes quiet
  assign restore = (state == ArbHold) & finalBeat & ~lsuActive;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ArbIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ArbIdle: begin
        if (save) begin
          nextState = ArbHold;
        end
      end
      ArbHold: begin
        // Leave once the parked fetch is taken by the bus
        if (restore & busReady) begin
          nextState = ArbIdle;
        end
      end
      default: nextState = ArbIdle;
    endcase
  end

  ////////////////////////////////////////
  // Burst beat counting
  ////////////////////////////////////////

  // Every accepted load/store beat
  // Load/store always owns the bus when active
  assign lsuBeat = busReady & lsuActive;

  // Delayed copy lags by one beat so a 16-beat burst fits in 4 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      beatCount  <= 4'd0;
      beatCountD <= 4'd0;
      burstD     <= HbSingle;
    end else if (lsuBeat) begin
      if (lsuReq.trans == HtNonSeq) begin
        beatCount  <= 4'd1;
        beatCountD <= 4'd0;
        burstD     <= lsuReq.burst;
      end else begin
        beatCount  <= beatCount + 4'd1;
        beatCountD <= beatCount;
      end
    end
  end

  // Beats minus one for each burst type
  always_comb begin
    case (burstD)
      HbIncr4:  threshold = 4'd3;
      HbIncr8:  threshold = 4'd7;
      HbIncr16: threshold = 4'd15;
      // Single and open-ended INCR hold for one beat only
      default:  threshold = 4'd0;
    endcase
  end

  // Last address beat of the burst has been accepted
  assign finalBeat = beatCountD >= threshold;

  ////////////////////////////////////////
  // Address and data phase muxing
  ////////////////////////////////////////

  // Fetch gets the bus only when load/store is quiet, or on replay
  assign fetchSel = ((state == ArbIdle) & ~lsuActive) | restore;

  always_comb begin
    if (fetchSel) begin
      busAddr.addr  = fetchOut.addr;
      busAddr.write = 1'b0;
      // Instruction reads are always a full word
      busAddr.size  = 3'b010;
      busAddr.burst = fetchOut.burst;
      busAddr.trans = fetchOut.trans;
    end else begin
      busAddr = lsuReq;
    end
  end

  // Load/store port is never stalled by arbitration
  assign lsuReady = busReady;

  // Only the load/store port writes
  assign busWdata = lsuWdata;
  assign busWstrb = lsuWstrb;

endmodule

//--- verilog/ahbMemory.sv
// AHB-Lite on-chip memory subordinate with byte strobes and wait states
`include "ahb_params.svh"

module ahbMemory import ahbPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  ahbAddrPhaseT       busAddr,
  input  logic [`XLEN-1:0]   busWdata,
  input  logic [`XLEN/8-1:0] busWstrb,
  output logic               busReady,
  output logic [`XLEN-1:0]   rdata
);

  localparam int IdxBits  = $clog2(`MEM_WORDS);
  localparam int WaitBits = (`MEM_WAIT_STATES > 0) ? $clog2(`MEM_WAIT_STATES + 1) : 1;

  logic [`XLEN-1:0]    mem [`MEM_WORDS] = '{default: '0};
  logic                dataActive;
  logic                dataWrite;
  logic [IdxBits-1:0]  dataIdx;
  logic [WaitBits-1:0] waitCnt;
  logic                accept;

  ////////////////////////////////////////
  // Data phase control
  ////////////////////////////////////////

  // Low only while wait states remain in a live data phase
  assign busReady = ~(dataActive & (waitCnt != '0));

  assign accept = busReady & ((busAddr.trans == HtNonSeq) | (busAddr.trans == HtSeq));

  always_ff @(posedge clk) begin
    if (reset) begin
      dataActive <= 1'b0;
      waitCnt    <= '0;
    end else if (accept) begin
      dataActive <= 1'b1;
      waitCnt    <= WaitBits'(`MEM_WAIT_STATES);
    end else if (busReady) begin
      dataActive <= 1'b0;
    end else begin
      waitCnt <= waitCnt - WaitBits'(1);
    end
  end

  // Word index wraps at the memory depth
  always_ff @(posedge clk) begin
    if (accept) begin
      dataWrite <= busAddr.write;
      dataIdx   <= busAddr.addr[IdxBits+1:2];
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Write lands on the edge that ends the data phase
  // Only strobed byte lanes change
  always_ff @(posedge clk) begin
    if (dataActive & busReady & dataWrite) begin
      for (int b = 0; b < `XLEN/8; b++) begin
        if (busWstrb[b]) begin
          mem[dataIdx][8*b +: 8] <= busWdata[8*b +: 8];
        end
      end
    end
  end

  // Held for the whole data phase, sampled when busReady rises
  assign rdata = mem[dataIdx];

endmodule

//--- verilog/ahbSubsystem.sv
// Top level wiring the two-manager arbiter to the memory subordinate
`include "ahb_params.svh"

module ahbSubsystem import ahbPkg::*, arbPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  fetchReqT           fetchReq,
  input  ahbAddrPhaseT       lsuReq,
  input  logic [`XLEN-1:0]   lsuWdata,
  input  logic [`XLEN/8-1:0] lsuWstrb,
  output logic               fetchReady,
  output logic               lsuReady,
  output logic [`XLEN-1:0]   rdata
);

  // Shared AHB-Lite bus between arbiter and memory
  ahbAddrPhaseT       busAddr;
  logic [`XLEN-1:0]   busWdata;
  logic [`XLEN/8-1:0] busWstrb;
  logic               busReady;

  // Arbiter in front of the bus
  ahbMultiManager i_ahbMultiManager (
    .clk        (clk),
    .reset      (reset),
    .fetchReq   (fetchReq),
    .lsuReq     (lsuReq),
    .lsuWdata   (lsuWdata),
    .lsuWstrb   (lsuWstrb),
    .busReady   (busReady),
    .fetchReady (fetchReady),
    .lsuReady   (lsuReady),
    .busAddr    (busAddr),
    .busWdata   (busWdata),
    .busWstrb   (busWstrb)
  );

  // Single subordinate, read data goes back to both ports
  ahbMemory i_ahbMemory (
    .clk      (clk),
    .reset    (reset),
    .busAddr  (busAddr),
    .busWdata (busWdata),
    .busWstrb (busWstrb),
    .busReady (busReady),
    .rdata    (rdata)
  );

endmodule

//--- verif/ahbSubsystemTb.sv
// Testbench with clock, reset, watchdog, reference memory, directed tests and closing report
`include "ahb_params.svh"

module ahbSubsystemTb import ahbPkg::*, arbPkg::*; ();

  localparam int ClkPeriod   = 8;
  localparam int HalfPeriod  = ClkPeriod / 2;
  localparam int ResetCycles = 16;
  localparam int WaitStates  = `MEM_WAIT_STATES;
  localparam int StallLimit  = 32;
  localparam int AltPairs    = 16;
  // Beats per test: 2 + 8 + 3 + 16 + 5, then two per alternating pair
  localparam int TotalBeats  = 34 + 2 * AltPairs;
  localparam int WatchdogTime = ResetCycles * ClkPeriod
                              + TotalBeats * (WaitStates + 2) * ClkPeriod * 4;

  logic               clk;
  logic               reset;
  fetchReqT           fetchReq;
  ahbAddrPhaseT       lsuReq;
  logic [`XLEN-1:0]   lsuWdata;
  logic [`XLEN/8-1:0] lsuWstrb;
  logic               fetchReady;
  logic               lsuReady;
  logic [`XLEN-1:0]   rdata;

  // Expected memory contents, indexed by word
  logic [`XLEN-1:0] refMem [`MEM_WORDS];
  // Per-beat write data and captured read data
  logic [`XLEN-1:0] lsuWbuf [16];
  logic [`XLEN-1:0] lsuRdata [16];
  logic [`XLEN-1:0] fetchData [16];

  integer seed;
  int     cycleCount    = 0;
  int     mismatchCount = 0;
  int     failCount     = 0;

  ahbSubsystem i_ahbSubsystem (
    .clk        (clk),
    .reset      (reset),
    .fetchReq   (fetchReq),
    .lsuReq     (lsuReq),
    .lsuWdata   (lsuWdata),
    .lsuWstrb   (lsuWstrb),
    .fetchReady (fetchReady),
    .lsuReady   (lsuReady),
    .rdata      (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // Rising edges seen so far, used to order data-phase ends
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  initial begin
    #(WatchdogTime);
    $display("Watchdog expired after %0d time units, the tests did not finish", WatchdogTime);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////

  // Word index wraps at the memory depth
  function automatic int refIndex(input logic [`PA_BITS-1:0] addr);
    return int'((addr >> 2) % `MEM_WORDS);
  endfunction

  // Only strobed byte lanes change
  function automatic void refWrite(input logic [`PA_BITS-1:0] addr,
                                   input logic [`XLEN-1:0] data,
                                   input logic [`XLEN/8-1:0] strb);
    int idx;
    idx = refIndex(addr);
    for (int b = 0; b < `XLEN/8; b++) begin
      if (strb[b]) begin
        refMem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic compareWord(input string name, input logic [`XLEN-1:0] expected,
                             input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic idleInputs();
    fetchReq.addr  = '0;
    fetchReq.burst = HbSingle;
    fetchReq.trans = HtIdle;
    lsuReq.addr    = '0;
    lsuReq.write   = 1'b0;
    lsuReq.size    = 3'b010;
    lsuReq.burst   = HbSingle;
    lsuReq.trans   = HtIdle;
    lsuWdata       = '0;
    lsuWstrb       = '0;
  endtask

  ////////////////////////////////////////
  // Manager drivers
  ////////////////////////////////////////

  // Pipelined load/store transfer, inputs change on the falling edge
  // and ready and rdata are sampled one time unit before the rising edge
  task automatic lsuBurst(input logic [`PA_BITS-1:0] startAddr, input int beats,
                          input hBurstT burst, input logic write,
                          input logic [`XLEN/8-1:0] strb,
                          output int cycles, output int doneCycle);
    int addrBeat;
    int dataBeat;
    int stall;
    addrBeat  = 0;
    dataBeat  = -1;
    stall     = 0;
    cycles    = 0;
    doneCycle = 0;
    while ((addrBeat < beats) || (dataBeat >= 0)) begin
      @(negedge clk);
      if (addrBeat < beats) begin
        lsuReq.addr  = startAddr + 4 * addrBeat;
        lsuReq.write = write;
        lsuReq.size  = 3'b010;
        lsuReq.burst = burst;
        lsuReq.trans = (addrBeat == 0) ? HtNonSeq : HtSeq;
      end else begin
        lsuReq.trans = HtIdle;
      end
      // Write data belongs to the beat in its data phase
      if (dataBeat >= 0) begin
        lsuWdata = lsuWbuf[dataBeat];
        lsuWstrb = strb;
      end
      #(HalfPeriod - 1);
      cycles++;
      if (lsuReady) begin
        stall = 0;
        if (dataBeat >= 0) begin
          if (!write) begin
            lsuRdata[dataBeat] = rdata;
          end
          doneCycle = cycleCount;
        end
        if (addrBeat < beats) begin
          dataBeat = addrBeat;
          addrBeat++;
        end else begin
          dataBeat = -1;
        end
      end else begin
        stall++;
        if (stall > StallLimit) begin
          failCount++;
          $display("Load/store port stalled for more than %0d cycles at %0t", StallLimit, $time);
          lsuReq.trans = HtIdle;
          return;
        end
      end
    end
  endtask

  // Same pipelining for the read-only fetch port
  task automatic fetchBurst(input logic [`PA_BITS-1:0] startAddr, input int beats,
                            input hBurstT burst, output int cycles, output int doneCycle);
    int addrBeat;
    int dataBeat;
    int stall;
    addrBeat  = 0;
    dataBeat  = -1;
    stall     = 0;
    cycles    = 0;
    doneCycle = 0;
    while ((addrBeat < beats) || (dataBeat >= 0)) begin
      @(negedge clk);
      if (addrBeat < beats) begin
        fetchReq.addr  = startAddr + 4 * addrBeat;
        fetchReq.burst = burst;
        fetchReq.trans = (addrBeat == 0) ? HtNonSeq : HtSeq;
      end else begin
        fetchReq.trans = HtIdle;
      end
      #(HalfPeriod - 1);
      cycles++;
      if (fetchReady) begin
        stall = 0;
        if (dataBeat >= 0) begin
          fetchData[dataBeat] = rdata;
          doneCycle = cycleCount;
        end
        if (addrBeat < beats) begin
          dataBeat = addrBeat;
          addrBeat++;
        end else begin
          dataBeat = -1;
        end
      end else begin
        stall++;
        if (stall > StallLimit) begin
          failCount++;
          $display("Fetch port stalled for more than %0d cycles at %0t", StallLimit, $time);
          fetchReq.trans = HtIdle;
          return;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testWriteThenFetch();
    logic [`PA_BITS-1:0] addr;
    int cycles;
    int done;
    addr = 32'h0000_0040;
    lsuWbuf[0] = $random(seed);
    lsuBurst(addr, 1, HbSingle, 1'b1, 4'hF, cycles, done);
    refWrite(addr, lsuWbuf[0], 4'hF);
    fetchBurst(addr, 1, HbSingle, cycles, done);
    compareWord("fetch rdata after write", refMem[refIndex(addr)], fetchData[0]);
  endtask

  task automatic testIncr4Bursts();
    logic [`PA_BITS-1:0] base;
    int cycles;
    int done;
    base = 32'h0000_0100;
    for (int i = 0; i < 4; i++) begin
      lsuWbuf[i] = $random(seed);
      refWrite(base + 4 * i, lsuWbuf[i], 4'hF);
    end
    lsuBurst(base, 4, HbIncr4, 1'b1, 4'hF, cycles, done);
    lsuBurst(base, 4, HbIncr4, 1'b0, 4'hF, cycles, done);
    for (int i = 0; i < 4; i++) begin
      compareWord("load/store INCR4 rdata", refMem[refIndex(base + 4 * i)], lsuRdata[i]);
    end
  endtask

  // Low two byte lanes only
  task automatic testPartialWrite();
    logic [`PA_BITS-1:0] addr;
    int cycles;
    int done;
    addr = 32'h0000_0200;
    lsuWbuf[0] = $random(seed);
    lsuBurst(addr, 1, HbSingle, 1'b1, 4'hF, cycles, done);
    refWrite(addr, lsuWbuf[0], 4'hF);
    lsuWbuf[0] = $random(seed);
    lsuBurst(addr, 1, HbSingle, 1'b1, 4'b0011, cycles, done);
    refWrite(addr, lsuWbuf[0], 4'b0011);
    lsuBurst(addr, 1, HbSingle, 1'b0, 4'hF, cycles, done);
    compareWord("rdata after partial write", refMem[refIndex(addr)], lsuRdata[0]);
  endtask

  task automatic testFetchIncr8();
    logic [`PA_BITS-1:0] base;
    int cycles;
    int done;
    base = 32'h0000_0300;
    for (int i = 0; i < 8; i++) begin
      lsuWbuf[i] = $random(seed);
      refWrite(base + 4 * i, lsuWbuf[i], 4'hF);
    end
    lsuBurst(base, 8, HbIncr8, 1'b1, 4'hF, cycles, done);
    fetchBurst(base, 8, HbIncr8, cycles, done);
    for (int i = 0; i < 8; i++) begin
      compareWord("fetch INCR8 rdata", refMem[refIndex(base + 4 * i)], fetchData[i]);
    end
  endtask

  // Both ports start together, fetch targets the first word of the burst
  task automatic testSimultaneousStart();
    logic [`PA_BITS-1:0] base;
    int lsuCycles;
    int lsuDone;
    int fetchCycles;
    int fetchDone;
    base = 32'h0000_0400;
    for (int i = 0; i < 4; i++) begin
      lsuWbuf[i] = $random(seed);
      refWrite(base + 4 * i, lsuWbuf[i], 4'hF);
    end
    fork
      lsuBurst(base, 4, HbIncr4, 1'b1, 4'hF, lsuCycles, lsuDone);
      fetchBurst(base, 1, HbSingle, fetchCycles, fetchDone);
    join
    // Only memory wait states may slow the load/store burst
    compareWord("load/store burst cycles", 4 * (WaitStates + 1) + 1, lsuCycles);
    if (fetchDone <= lsuDone) begin
      failCount++;
      $display("Fetch data phase ended in cycle %0d, before the load/store burst ended in %0d",
               fetchDone, lsuDone);
    end
    compareWord("replayed fetch rdata", refMem[refIndex(base)], fetchData[0]);
  endtask

  task automatic testAlternating();
    logic [`PA_BITS-1:0] addr;
    logic [31:0] rnd;
    int cycles;
    int done;
    for (int n = 0; n < AltPairs; n++) begin
      addr = $random(seed);
      addr[1:0] = 2'b00;
      // Bit 0 picks write, bits 7:4 the strobes, bit 8 a fresh fetch address
      rnd = $random(seed);
      lsuWbuf[0] = $random(seed);
      lsuBurst(addr, 1, HbSingle, rnd[0], rnd[7:4], cycles, done);
      if (rnd[0]) begin
        refWrite(addr, lsuWbuf[0], rnd[7:4]);
      end else begin
        compareWord("load/store single rdata", refMem[refIndex(addr)], lsuRdata[0]);
      end
      if (rnd[8]) begin
        addr = $random(seed);
        addr[1:0] = 2'b00;
      end
      fetchBurst(addr, 1, HbSingle, cycles, done);
      compareWord("fetch single rdata", refMem[refIndex(addr)], fetchData[0]);
    end
  endtask

  initial begin
    seed  = 32'h3d74_0737;
    reset = 1'b1;
    idleInputs();
    for (int i = 0; i < `MEM_WORDS; i++) begin
      refMem[i] = '0;
    end
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    // Both managers see a ready bus out of reset
    #(HalfPeriod - 1);
    if (lsuReady !== 1'b1) begin
      mismatchCount++;
      $display("Mismatch at %0t: lsuReady expected 1, actual %b", $time, lsuReady);
    end
    if (fetchReady !== 1'b1) begin
      mismatchCount++;
      $display("Mismatch at %0t: fetchReady expected 1, actual %b", $time, fetchReady);
    end
    testWriteThenFetch();
    testIncr4Bursts();
    testPartialWrite();
    testFetchIncr8();
    testSimultaneousStart();
    testAlternating();
    $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
    if ((mismatchCount == 0) && (failCount == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
verilog/ahbPkg.sv
verilog/arbPkg.sv
verilog/fetchInputStage.sv
verilog/ahbMultiManager.sv
verilog/ahbMemory.sv
verilog/ahbSubsystem.sv
verif/ahbSubsystemTb.sv

//--- Makefile
# Verilator build and run for the AHB subsystem testbench
# Override on the command line, for example: make run WAIT_STATES=1

VERILATOR   ?= verilator
TOP         ?= ahbSubsystemTb
FILELIST    ?= src.f
WAIT_STATES ?= 0
BUILD_DIR   ?= obj_dir_ws$(WAIT_STATES)
LOG         ?= sim_ws$(WAIT_STATES).log
VFLAGS      ?= --binary -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run regress clean

all: run

build: $(SIM_BIN)

# One build directory per wait-state setting, rebuilt only when a source changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  +define+MEM_WAIT_STATES=$(WAIT_STATES) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
	  echo "Simulation failed with $(WAIT_STATES) wait states, see $(LOG)"; exit 1; fi

regress:
	$(MAKE) run WAIT_STATES=0
	$(MAKE) run WAIT_STATES=1

clean:
	rm -rf obj_dir_ws* sim_ws*.log
